/* source/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	// general register number, 32 registers
	typedef logic [4:0] regAddrT;

	// R-type layout of an instruction word
	// COP0 words use the same split
	typedef struct packed {
		// major opcode, bits 31:26
		logic [5:0] op;
		// bits 25:21, selects MF / MT / CO group on COP0
		logic [4:0] rs;
		// bits 20:16, GPR side of MFC0 / MTC0
		regAddrT    rt;
		// bits 15:11, CP0 register number on MFC0 / MTC0
		regAddrT    rd;
		// bits 10:6
		logic [4:0] shamt;
		// bits 5:0, sel lives in the low 3 bits
		logic [5:0] funct;
	} instrT;

	// major opcodes
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opCop0    = 6'b010000;

	// rs codes inside COP0
	// move from coprocessor
	localparam logic [4:0] rsMf = 5'b00000;
	// move to coprocessor
	localparam logic [4:0] rsMt = 5'b00100;
	// CO group, bit 25 set
	localparam logic [4:0] rsCo = 5'b10000;

	// function codes
	// SPECIAL group
	localparam logic [5:0] functSyscall = 6'b001100;
	// COP0 CO group
	localparam logic [5:0] functEret    = 6'b011000;

endpackage

`default_nettype wire

/* source/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

	// word PC holding byte address bits 31:2
	typedef logic [29:0] pcT;

	// coprocessor request kind
	// fixed encodings 0 to 4
	typedef enum logic [2:0] {
		cp0None    = 3'd0,
		cp0Mfc0    = 3'd1,
		cp0Mtc0    = 3'd2,
		cp0Syscall = 3'd3,
		cp0Eret    = 3'd4
	} cp0OpT;

	// CP0 register address as {cs, sel}
	typedef struct packed {
		logic [4:0] cs;
		logic [2:0] sel;
	} cp0AddrT;

	// implemented registers at 96 / 104 / 112 as 8-bit values
	localparam cp0AddrT addrStatus = '{cs: 5'd12, sel: 3'd0};
	localparam cp0AddrT addrCause  = '{cs: 5'd13, sel: 3'd0};
	localparam cp0AddrT addrEpc    = '{cs: 5'd14, sel: 3'd0};

	// Cause.ExcCode for system call
	localparam logic [4:0] excSyscall = 5'd8;
	// ExcCode field position inside Cause
	localparam int causeExcLo = 2;
	localparam int causeExcHi = 6;

	// Status.EXL
	localparam int statusExlBit = 1;

	// boot vector 0xBFC00000 as word address
	localparam pcT resetPc     = 30'h2FF0_0000;
	// general exception vector 0x80000180 as word address
	localparam pcT excVectorPc = 30'h2000_0060;

	// one decoded coprocessor request per cycle
	typedef struct packed {
		cp0OpT              op;
		cp0AddrT            addr;
		// GPR written by MFC0, read by MTC0
		mipsIsaPkg::regAddrT rt;
	} cp0ReqT;

endpackage

`default_nettype wire

/* source/cp0Decode.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Decode (
	input  wire logic [31:0]    instr,
	output cp0Pkg::cp0ReqT      req
);

	import mipsIsaPkg::*;
	import cp0Pkg::*;

	// field view of the fetched word
	instrT word;

	// group flags
	logic isCop0;
	logic isSpecial;

	assign word = instrT'(instr);

	assign isCop0    = (word.op == opCop0);
	assign isSpecial = (word.op == opSpecial);

	always_comb begin
		// address and destination are passed through for every word
		// only op decides whether anybody looks at them
		req.addr.cs  = word.rd;
		req.addr.sel = word.funct[2:0];
		req.rt       = word.rt;

		// default is a plain no-op for the coprocessor
		req.op = cp0None;

		if (isCop0) begin
			// COP0 group, rs picks the sub-op
			if (word.rs == rsMf) begin
				req.op = cp0Mfc0;
			end else if (word.rs == rsMt) begin
				req.op = cp0Mtc0;
			end else if (word.rs == rsCo && word.funct == functEret) begin
				// only ERET is known in the CO group
				req.op = cp0Eret;
			end
		end else if (isSpecial) begin
			// code field of SYSCALL is ignored
			if (word.funct == functSyscall) begin
				req.op = cp0Syscall;
			end
		end
	end

endmodule

`default_nettype wire

/* source/cp0Regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Regs (
	input  wire logic           clk,
	input  wire logic           arstN,
	input  cp0Pkg::cp0ReqT      req,
	// value of GPR rt for MTC0
	input  wire logic [31:0]    wrData,
	// PC of the current word, captured on SYSCALL
	input  cp0Pkg::pcT          pc,
	output logic [31:0]         rdData,
	output logic                rdValid,
	// return address for ERET
	output cp0Pkg::pcT          epc
);

	import cp0Pkg::*;

	// architectural registers
	logic [31:0] status;
	logic [31:0] cause;
	// byte address of the faulting word
	logic [31:0] epcReg;

	// read side
	// unknown addresses read as zero
	always_comb begin
		case (req.addr)
			addrStatus: rdData = status;
			addrCause:  rdData = cause;
			addrEpc:    rdData = epcReg;
			default:    rdData = '0;
		endcase
	end

	// write-back only for MFC0
	assign rdValid = (req.op == cp0Mfc0);

	// word part of EPC goes to the PC unit
	// pre-edge value, so ERET sees the old register
	assign epc = epcReg[31:2];

	// update side
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			status <= '0;
			cause  <= '0;
			epcReg <= '0;
		end else begin
			case (req.op)
				cp0Mtc0: begin
					// writes to unknown registers are dropped
					case (req.addr)
						addrStatus: status <= wrData;
						addrCause:  cause  <= wrData;
						addrEpc:    epcReg <= wrData;
						default: begin
						end
					endcase
				end
				cp0Syscall: begin
					// exception entry
					// EPC overwritten even with EXL set
					epcReg                      <= {pc, 2'b00};
					cause[causeExcHi:causeExcLo] <= excSyscall;
					status[statusExlBit]        <= 1'b1;
				end
				cp0Eret: begin
					// leave exception level, rest of Status kept
					status[statusExlBit] <= 1'b0;
				end
				default: begin
					// MFC0 and no-ops leave the bank alone
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/pcNext.sv */
`timescale 1ns/1ns
`default_nettype none

module pcNext (
	input  wire logic       clk,
	input  wire logic       arstN,
	input  cp0Pkg::cp0OpT   op,
	// return target from the CP0 bank
	input  cp0Pkg::pcT      epc,
	output cp0Pkg::pcT      pc
);

	import cp0Pkg::*;

	// successor of the current word
	pcT nextPc;

	// next fetch address
	always_comb begin
		case (op)
			// trap to the general vector
			cp0Syscall: nextPc = excVectorPc;
			// back to the stored return address
			cp0Eret:    nextPc = epc;
			// everything else falls through by one word
			default:    nextPc = pc + 30'd1;
		endcase
	end

	// PC register
	// boots at the reset vector
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* source/cp0Subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Subsystem (
	input  wire logic               clk,
	input  wire logic               arstN,
	// word at the current pc
	input  wire logic [31:0]        instr,
	// value of register rt
	input  wire logic [31:0]        rtData,
	output cp0Pkg::pcT              pc,
	// GPR write port towards the register file
	output logic                    regWrite,
	output mipsIsaPkg::regAddrT     regWriteAddr,
	output logic [31:0]             regWriteData
);

	import cp0Pkg::*;

	// decoded request, shared by bank and PC unit
	cp0ReqT req;
	// bank read result
	logic [31:0] rdData;
	logic rdValid;
	// ERET target
	pcT epc;

	// instruction to request
	cp0Decode i_decode (
		.instr (instr),
		.req   (req)
	);

	// Status / Cause / EPC
	cp0Regs i_regs (
		.clk     (clk),
		.arstN   (arstN),
		.req     (req),
		.wrData  (rtData),
		.pc      (pc),
		.rdData  (rdData),
		.rdValid (rdValid),
		.epc     (epc)
	);

	// fetch address
	pcNext i_pc (
		.clk   (clk),
		.arstN (arstN),
		.op    (req.op),
		.epc   (epc),
		.pc    (pc)
	);

	// MFC0 result goes straight out in the same cycle
	assign regWrite     = rdValid;
	assign regWriteAddr = req.rt;
	assign regWriteData = rdData;

endmodule

`default_nettype wire

/* tests/cp0Subsystem_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0SubsystemSva (
	input  wire logic        clk,
	input  wire logic        arstN,
	input  wire logic [31:0] instr,
	input  cp0Pkg::pcT       pc,
	input  wire logic        regWrite
);

	import mipsIsaPkg::*;
	import cp0Pkg::*;

	// failures seen so far, read by the bench
	int assertFails = 0;

	// word classes straight from the opcode fields
	logic isSyscall;
	logic isMfc0;

	assign isSyscall = (instr[31:26] == opSpecial) && (instr[5:0] == functSyscall);
	assign isMfc0    = (instr[31:26] == opCop0) && (instr[25:21] == rsMf);

	// boot vector held through reset
	resetPcHeld: assert property (@(posedge clk) !arstN |-> pc == resetPc)
		else begin
			$error("pc left the reset vector while reset was low");
			assertFails++;
		end

	// trap goes to the general vector
	syscallVector: assert property (
		@(posedge clk) disable iff (!arstN) isSyscall |=> pc == excVectorPc)
		else begin
			$error("pc did not reach the exception vector after SYSCALL");
			assertFails++;
		end

	// write port only used by MFC0
	writeOnlyOnMfc0: assert property (@(posedge clk) regWrite |-> isMfc0)
		else begin
			$error("regWrite high for a word that is not MFC0");
			assertFails++;
		end

endmodule

bind cp0Subsystem cp0SubsystemSva i_sva (
	.clk      (clk),
	.arstN    (arstN),
	.instr    (instr),
	.pc       (pc),
	.regWrite (regWrite)
);

`default_nettype wire

/* tests/cp0Checker.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Checker (
	input  wire logic            clk,
	// high while a data-file line is applied
	input  wire logic            checkEn,
	input  int                   lineIdx,
	// expected pc as byte address
	input  wire logic [31:0]     expPc,
	input  wire logic            expRegWrite,
	input  mipsIsaPkg::regAddrT  expRegWriteAddr,
	input  wire logic [31:0]     expRegWriteData,
	// DUT outputs
	input  cp0Pkg::pcT           pc,
	input  wire logic            regWrite,
	input  mipsIsaPkg::regAddrT  regWriteAddr,
	input  wire logic [31:0]     regWriteData,
	output int                   checkCount,
	output int                   errorCount
);

	// one field compare, ERR line on mismatch
	task automatic compareField(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected) begin
			$display("ERR %s expected 0x%08h actual 0x%08h (line %0d, %0t ns)",
				name, expected, actual, lineIdx, $time);
			errorCount++;
		end
	endtask

	initial begin
		checkCount = 0;
		errorCount = 0;
		forever begin
			// second half of the cycle
			// outputs settled, next rising edge still ahead
			@(negedge clk);
			if (checkEn) begin
				checkCount++;
				// port is a word address
				compareField("pc", expPc, {pc, 2'b00});
				compareField("regWrite", 32'(expRegWrite), 32'(regWrite));
				// address and data only matter on a write
				if (expRegWrite) begin
					compareField("regWriteAddr", 32'(expRegWriteAddr), 32'(regWriteAddr));
					compareField("regWriteData", expRegWriteData, regWriteData);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tests/cp0SubsystemTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0SubsystemTb;

	import mipsIsaPkg::*;
	import cp0Pkg::*;

	// one line of the data file
	// widths rounded up to whole hex digits
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] rtData;
		// byte address
		logic [31:0] expPc;
		logic [3:0]  expRegWrite;
		logic [7:0]  expRegWriteAddr;
		logic [31:0] expRegWriteData;
	} lineT;

	// DUT ports
	logic        clk;
	logic        arstN;
	logic [31:0] instr;
	logic [31:0] rtData;
	pcT          pc;
	logic        regWrite;
	regAddrT     regWriteAddr;
	logic [31:0] regWriteData;

	// stimulus table
	lineT lines [64];
	int   lineCount;
	logic loadDone;

	// line currently applied and seen by the checker
	lineT cur;
	int   lineIdx;
	logic checkEn;

	// checker totals
	int checkCount;
	int errorCount;

	// slot fill tied to the slot index
	// first slot still holding it marks the end of the file
	function automatic lineT fillLine(input int idx);
		lineT fill;
		fill.instr           = idx;
		fill.rtData          = ~idx;
		fill.expPc           = idx;
		fill.expRegWrite     = idx[3:0];
		fill.expRegWriteAddr = idx[7:0];
		fill.expRegWriteData = ~idx;
		return fill;
	endfunction

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	cp0Subsystem i_dut (
		.clk          (clk),
		.arstN        (arstN),
		.instr        (instr),
		.rtData       (rtData),
		.pc           (pc),
		.regWrite     (regWrite),
		.regWriteAddr (regWriteAddr),
		.regWriteData (regWriteData)
	);

	cp0Checker i_checker (
		.clk             (clk),
		.checkEn         (checkEn),
		.lineIdx         (lineIdx),
		.expPc           (cur.expPc),
		.expRegWrite     (cur.expRegWrite[0]),
		.expRegWriteAddr (cur.expRegWriteAddr[4:0]),
		.expRegWriteData (cur.expRegWriteData),
		.pc              (pc),
		.regWrite        (regWrite),
		.regWriteAddr    (regWriteAddr),
		.regWriteData    (regWriteData),
		.checkCount      (checkCount),
		.errorCount      (errorCount)
	);

	initial begin : stimulus
		int   i;
		logic passed;
		arstN     <= 1'b1;
		instr     <= '0;
		rtData    <= '0;
		cur       <= '0;
		lineIdx   <= 0;
		checkEn   <= 1'b0;
		loadDone  = 1'b0;
		lineCount = 0;
		for (i = 0; i < $size(lines); i++) begin
			lines[i] = fillLine(i);
		end
		$readmemh("tests/cp0Input.dat", lines);
		while (lineCount < $size(lines) && lines[lineCount] != fillLine(lineCount)) begin
			lineCount++;
		end
		loadDone = 1'b1;
		if (lineCount == 0) begin
			$display("no stimulus lines could be read from tests/cp0Input.dat");
		end

		// falling edge away from the clock so the flops reset at once
		#1;
		arstN <= 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;

		// one line per cycle
		for (i = 0; i < lineCount; i++) begin
			instr   <= lines[i].instr;
			rtData  <= lines[i].rtData;
			cur     <= lines[i];
			lineIdx <= i;
			checkEn <= 1'b1;
			@(posedge clk);
		end
		checkEn <= 1'b0;

		passed = (lineCount > 0) && (checkCount == lineCount) && (errorCount == 0)
			&& (i_dut.i_sva.assertFails == 0);
		$display("checks %0d of %0d lines, value errors %0d, assertion failures %0d",
			checkCount, lineCount, errorCount, i_dut.i_sva.assertFails);
		if (passed) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (loadDone);
		// one cycle per line plus ten spare cycles
		#((lineCount + 10) * 4);
		$display("watchdog expired after %0d cycles before all lines were applied",
			lineCount + 10);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/cp0Input.dat */
// columns instr rtData pc regWrite regWriteAddr regWriteData, all hex
// pc is the expected byte address, one line per cycle
// reset and counting
00000000_00000000_bfc00000_0_00_00000000
24020005_00000000_bfc00004_0_00_00000000
// MTC0 to Status, Cause, EPC and unknown 12,1
40886000_0000ff00_bfc00008_0_00_00000000
40896800_00c00304_bfc0000c_0_00_00000000
408a7000_80001000_bfc00010_0_00_00000000
408b6001_deadbeef_bfc00014_0_00_00000000
// MFC0 reads back
40026000_ffffffff_bfc00018_1_02_0000ff00
40036800_00000000_bfc0001c_1_03_00c00304
40047000_00000000_bfc00020_1_04_80001000
40056001_00000000_bfc00024_1_05_00000000
40066000_00000000_bfc00028_1_06_0000ff00
// SYSCALL entry then EPC, Cause, Status
0000000c_00000000_bfc0002c_0_00_00000000
40077000_00000000_80000180_1_07_bfc0002c
40086800_00000000_80000184_1_08_00c00320
40096000_00000000_80000188_1_09_0000ff02
// ERET back to EPC, EXL clear
42000018_00000000_8000018c_0_00_00000000
400a6000_00000000_bfc0002c_1_0a_0000ff00
// EPC rewritten before ERET
0000000c_00000000_bfc00030_0_00_00000000
408c7000_bfc00100_80000180_0_00_00000000
42000018_00000000_80000184_0_00_00000000
400d7000_00000000_bfc00100_1_0d_bfc00100
00000000_00000000_bfc00104_0_00_00000000

/* src.f */
source/mipsIsaPkg.sv
source/cp0Pkg.sv
source/cp0Decode.sv
source/cp0Regs.sv
source/pcNext.sv
source/cp0Subsystem.sv
tests/cp0Subsystem_sva.sv
tests/cp0Checker.sv
tests/cp0SubsystemTb.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := cp0SubsystemTb
FILELIST := src.f
OBJDIR   := obj_dir
PASSMSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the bench prints its pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
